/* dv/rx_cal_chk.sv */
// Protocol checks on the lane sequencer and its sweep engine

`timescale 1ns/10ps

module rx_cal_chk #(
  parameter int CODE_W = 5
) (
  input logic                   sys_clk,
  input logic                   rst_n,
  input logic                   cal_busy,
  input logic                   cal_done,
  input logic                   step_en,
  input logic                   eng_start,
  input logic [CODE_W-1:0]      eng_code,
  input rx_cal_pkg::cal_state_t eng_state
);

  import rx_cal_pkg::*;

  localparam logic [CODE_W-1:0] CODE_MAX = '1;

  // Failed assertion count
  int fail_cnt = 0;

  a_done_not_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
    cal_done |-> (!cal_busy && eng_state == CAL_IDLE))
    else begin
      $error("cal_done high while the sequencer or engine is still busy");
      fail_cnt++;
    end

  // Code holds at the top instead of wrapping back to zero
  a_up_in_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (eng_state == CAL_UP && eng_code == CODE_MAX) |=> (eng_code == CODE_MAX))
    else begin
      $error("engine code went past the highest code in the up sweep");
      fail_cnt++;
    end

  a_idle_needs_start: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (eng_state == CAL_IDLE && !eng_start) |=> (eng_state == CAL_IDLE))
    else begin
      $error("engine left idle without a start");
      fail_cnt++;
    end

  a_hold_without_step: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !step_en |=> $stable(eng_state))
    else begin
      $error("engine state changed on a cycle without step_en");
      fail_cnt++;
    end

endmodule

/* dv/rx_cal_clk_gen.sv */
// Testbench clock and reset source
// Free-running sys_clk and an active-low reset held for a set number of cycles

`timescale 1ns/10ps

module rx_cal_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic sys_clk,
  output logic rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge sys_clk);
    rst_n <= 1'b1;
  end

endmodule

/* dv/rx_cal_monitor.sv */
// Calibration result monitor
// Predicts each lane's trim and fail flag from the stimulus and flags mismatches

`timescale 1ns/10ps

module rx_cal_monitor #(
  parameter int NUM_LANES = 4,
  parameter int CODE_W    = 5
) (
  input  logic                        sys_clk,
  input  logic                        rst_n,
  input  logic                        start_cal,
  input  logic [NUM_LANES*CODE_W-1:0] lane_trim,
  input  logic                        cal_busy,
  input  logic                        cal_done,
  input  logic [NUM_LANES-1:0]        cal_fail,
  input  logic [NUM_LANES*8-1:0]      thr_vec,
  input  logic [NUM_LANES*8-1:0]      hys_vec,
  input  logic [NUM_LANES-1:0]        stuck_vec,
  input  logic                        cmp_req,
  input  logic                        miss_req,
  output int                          value_errs,
  output int                          other_errs
);

  localparam int CODE_MAX = (1 << CODE_W) - 1;

  int   value_cnt = 0;
  int   other_cnt = 0;
  logic done_q    = 1'b0;
  logic start_q   = 1'b0;

  assign value_errs = value_cnt;
  assign other_errs = other_cnt;

  // No up trip when stuck low or when T + h lies above the code range
  function automatic logic expected_fail(input int t, input int h, input logic stuck);
    return stuck || (t + h > CODE_MAX);
  endfunction

  function automatic int expected_trim(input int t, input int h, input logic stuck);
    int up_pt;
    int dn_pt;
    if (expected_fail(t, h, stuck)) begin
      up_pt = CODE_MAX;
      dn_pt = 0;
    end else begin
      up_pt = t + h;
      dn_pt = (t - h > 0) ? t - h : 0;
    end
    return (up_pt + dn_pt) / 2;
  endfunction

  always @(posedge sys_clk) begin : watch
    int   l;
    int   t;
    int   h;
    int   exp_trim;
    int   act_trim;
    logic exp_fail;
    if (!rst_n) begin
      if (lane_trim != '0 || cal_fail != '0 || cal_busy || cal_done) begin
        value_cnt = value_cnt + 1;
        $display("ERROR reset state lane_trim=0x%0h cal_fail=0x%0h cal_busy=0x%0h cal_done=0x%0h",
                 lane_trim, cal_fail, cal_busy, cal_done);
      end
    end else begin
      if (!start_cal && cal_busy) begin
        other_cnt = other_cnt + 1;
        $display("cal_busy was high while the controller was idle at %0t", $time);
      end
      // Busy covers the whole run until done rises
      if (start_q && start_cal && !cal_done && !cal_busy) begin
        other_cnt = other_cnt + 1;
        $display("cal_busy was low during a calibration run at %0t", $time);
      end
      // Done level must persist while start is still held
      if (done_q && start_q && !cal_done) begin
        other_cnt = other_cnt + 1;
        $display("cal_done dropped while start_cal was still high at %0t", $time);
      end
      if (miss_req) begin
        other_cnt = other_cnt + 1;
        $display("cal_done never rose, or never cleared, within the row time limit");
      end
      if (cmp_req) begin
        if (!cal_done) begin
          value_cnt = value_cnt + 1;
          $display("ERROR cal_done expected 0x1 actual 0x%0h", cal_done);
        end
        for (l = 0; l < NUM_LANES; l++) begin
          t        = int'(thr_vec[l*8 +: 8]);
          h        = int'(hys_vec[l*8 +: 8]);
          exp_trim = expected_trim(t, h, stuck_vec[l]);
          exp_fail = expected_fail(t, h, stuck_vec[l]);
          act_trim = int'(lane_trim[l*CODE_W +: CODE_W]);
          if (act_trim != exp_trim) begin
            value_cnt = value_cnt + 1;
            $display("ERROR lane_trim[%0d] expected 0x%0h actual 0x%0h", l, exp_trim, act_trim);
          end
          if (cal_fail[l] !== exp_fail) begin
            value_cnt = value_cnt + 1;
            $display("ERROR cal_fail[%0d] expected 0x%0h actual 0x%0h", l, exp_fail, cal_fail[l]);
          end
        end
      end
    end
    done_q  <= cal_done;
    start_q <= start_cal;
  end

endmodule

/* dv/tb_rx_cal.sv */
// Receiver offset calibration testbench
// Hysteretic comparator models per lane, a table of calibration runs and a watchdog

`timescale 1ns/10ps

module tb_rx_cal;

  import rx_cal_pkg::*;

  localparam int     NUM_LANES   = 4;
  localparam int     CODE_W      = 5;
  localparam int     CODE_MAX    = (1 << CODE_W) - 1;
  localparam int     NUM_ROWS    = 8;
  localparam int     LANE_STEPS  = 2 * (1 << CODE_W) + 8;
  localparam int     ROW_LIMIT   = NUM_LANES * LANE_STEPS * 8 * 2;
  localparam longint WD_NS       = longint'(NUM_ROWS) * NUM_LANES * LANE_STEPS * 8 * 40 + 20000;

  logic                        sys_clk;
  logic                        rst_n;
  logic                        start_cal;
  step_div_t                   step_div;
  logic [NUM_LANES-1:0]        comp_out;
  logic [NUM_LANES*CODE_W-1:0] lane_trim;
  logic                        cal_busy;
  logic                        cal_done;
  logic [NUM_LANES-1:0]        cal_fail;
  logic [NUM_LANES*8-1:0]      thr_vec;
  logic [NUM_LANES*8-1:0]      hys_vec;
  logic [NUM_LANES-1:0]        stuck_vec;
  logic [NUM_LANES-1:0]        hys_mem;
  logic                        cmp_req;
  logic                        miss_req;
  int                          value_errs;
  int                          other_errs;

  step_div_t row_div   [NUM_ROWS];
  int        row_thr   [NUM_ROWS][NUM_LANES];
  int        row_hys   [NUM_ROWS][NUM_LANES];
  logic      row_stuck [NUM_ROWS][NUM_LANES];

  rx_cal_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clk_gen (
    .sys_clk (sys_clk),
    .rst_n   (rst_n)
  );

  rx_cal_top #(.NUM_LANES(NUM_LANES), .CODE_W(CODE_W)) dut (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .start_cal (start_cal),
    .step_div  (step_div),
    .comp_out  (comp_out),
    .lane_trim (lane_trim),
    .cal_busy  (cal_busy),
    .cal_done  (cal_done),
    .cal_fail  (cal_fail)
  );

  rx_cal_monitor #(.NUM_LANES(NUM_LANES), .CODE_W(CODE_W)) u_monitor (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .start_cal  (start_cal),
    .lane_trim  (lane_trim),
    .cal_busy   (cal_busy),
    .cal_done   (cal_done),
    .cal_fail   (cal_fail),
    .thr_vec    (thr_vec),
    .hys_vec    (hys_vec),
    .stuck_vec  (stuck_vec),
    .cmp_req    (cmp_req),
    .miss_req   (miss_req),
    .value_errs (value_errs),
    .other_errs (other_errs)
  );

  bind rx_cal_sequencer rx_cal_chk #(.CODE_W(CODE_W)) u_chk (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .cal_busy  (cal_busy),
    .cal_done  (cal_done),
    .step_en   (step_en),
    .eng_start (eng_start),
    .eng_code  (eng_code),
    .eng_state (u_offset_cal.cur_state)
  );

  // High at or above T + h, low below T - h, otherwise holds
  function automatic logic comp_level(input int code, input int t, input int h,
                                      input logic stuck, input logic mem);
    if (stuck) return 1'b0;
    if (code >= t + h) return 1'b1;
    if (code < t - h) return 1'b0;
    return mem;
  endfunction

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      comp_out[l] = comp_level(int'(lane_trim[l*CODE_W +: CODE_W]), int'(thr_vec[l*8 +: 8]),
                               int'(hys_vec[l*8 +: 8]), stuck_vec[l], hys_mem[l]);
    end
  end

  // Comparator memory forgets its state between runs
  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      hys_mem <= '0;
    end else begin
      hys_mem <= cal_busy ? comp_out : '0;
    end
  end

  task automatic set_row(input int r, input step_div_t div, input int t0, input int t1,
                         input int t2, input int t3, input int h0, input int h1,
                         input int h2, input int h3, input logic [3:0] stuck);
    row_div[r]    = div;
    row_thr[r][0] = t0;
    row_thr[r][1] = t1;
    row_thr[r][2] = t2;
    row_thr[r][3] = t3;
    row_hys[r][0] = h0;
    row_hys[r][1] = h1;
    row_hys[r][2] = h2;
    row_hys[r][3] = h3;
    for (int l = 0; l < NUM_LANES; l++) begin
      row_stuck[r][l] = stuck[l];
    end
  endtask

  task automatic build_table();
    logic [1:0] div_bits;
    int         h;
    set_row(0, DIV1, 5, 12, 20, 27, 0, 0, 0, 0, 4'b0000);
    // Lane 0 down trip clips below code 0
    set_row(1, DIV1, 2, 9, 17, 24, 3, 1, 2, 3, 4'b0000);
    set_row(2, DIV2, 10, 14, 19, 23, 1, 2, 0, 3, 4'b0000);
    set_row(3, DIV4, 10, 14, 19, 23, 1, 2, 0, 3, 4'b0000);
    set_row(4, DIV8, 10, 14, 19, 23, 1, 2, 0, 3, 4'b0000);
    set_row(5, DIV1, 8, 16, 22, 29, 0, 1, 1, 2, 4'b0100);
    for (int r = 6; r < NUM_ROWS; r++) begin
      div_bits   = 2'($urandom_range(3, 0));
      row_div[r] = step_div_t'(div_bits);
      for (int l = 0; l < NUM_LANES; l++) begin
        h               = int'($urandom_range(3, 0));
        row_hys[r][l]   = h;
        row_thr[r][l]   = int'($urandom_range(CODE_MAX - h, h + 1));
        row_stuck[r][l] = 1'b0;
      end
    end
  endtask

  task automatic apply_row(input int r);
    logic [NUM_LANES*8-1:0] thr_next;
    logic [NUM_LANES*8-1:0] hys_next;
    logic [NUM_LANES-1:0]   stuck_next;
    for (int l = 0; l < NUM_LANES; l++) begin
      thr_next[l*8 +: 8] = 8'(row_thr[r][l]);
      hys_next[l*8 +: 8] = 8'(row_hys[r][l]);
      stuck_next[l]      = row_stuck[r][l];
    end
    @(posedge sys_clk);
    step_div  <= row_div[r];
    thr_vec   <= thr_next;
    hys_vec   <= hys_next;
    stuck_vec <= stuck_next;
  endtask

  task automatic wait_done_level(input logic level, output logic seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < ROW_LIMIT) begin
      @(posedge sys_clk);
      cycles++;
      seen = (cal_done == level);
    end
  endtask

  task automatic pulse_miss();
    @(posedge sys_clk);
    miss_req <= 1'b1;
    @(posedge sys_clk);
    miss_req <= 1'b0;
  endtask

  initial begin : main
    logic seen;
    int   assert_errs;
    void'($urandom(32'h3f321a50));
    start_cal = 1'b0;
    step_div  = DIV1;
    thr_vec   = '0;
    hys_vec   = '0;
    stuck_vec = '0;
    cmp_req   = 1'b0;
    miss_req  = 1'b0;
    build_table();
    @(posedge rst_n);
    repeat (4) @(posedge sys_clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
      @(posedge sys_clk);
      start_cal <= 1'b1;
      wait_done_level(1'b1, seen);
      if (seen) begin
        // Hold start a while so the done level is seen to persist
        repeat (3) @(posedge sys_clk);
        cmp_req <= 1'b1;
        @(posedge sys_clk);
        cmp_req <= 1'b0;
      end else begin
        pulse_miss();
      end
      start_cal <= 1'b0;
      wait_done_level(1'b0, seen);
      if (!seen) begin
        pulse_miss();
      end
      repeat (4) @(posedge sys_clk);
    end
    repeat (4) @(posedge sys_clk);
    assert_errs = dut.u_sequencer.u_chk.fail_cnt;
    $display("Run complete: value errors %0d, other errors %0d, assertion errors %0d",
             value_errs, other_errs, assert_errs);
    if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WD_NS);
    $display("Watchdog expired before all calibration rows finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* hw/cal_step_timer.sv */
// Calibration step timer
// Free-running divider that strobes step_en once per selected number of clocks

`timescale 1ns/10ps

module cal_step_timer (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  rx_cal_pkg::step_div_t step_div,
  output logic                  step_en
);

  import rx_cal_pkg::*;

  logic [2:0] div_cnt;
  logic [2:0] div_mask;

  // Counter bits that must all be set for a strobe
  always_comb begin
    case (step_div)
      DIV1:    div_mask = 3'b000;
      DIV2:    div_mask = 3'b001;
      DIV4:    div_mask = 3'b011;
      default: div_mask = 3'b111;
    endcase
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= 3'b000;
      step_en <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      // Empty mask under DIV1 keeps the strobe high every cycle
      step_en <= ((div_cnt & div_mask) == div_mask);
    end
  end

endmodule

/* hw/rx_cal_pkg.sv */
// Receiver offset calibration shared types
// State encodings for the sweep engine and lane sequencer, and the step pace select

package rx_cal_pkg;

  // Sweep engine states
  typedef enum logic [2:0] {
    CAL_IDLE = 3'b000,
    CAL_UP   = 3'b001,
    CAL_ROLL = 3'b010,
    CAL_DOWN = 3'b011,
    CAL_DONE = 3'b100
  } cal_state_t;

  // Lane sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE   = 3'b000,
    SEQ_RUN    = 3'b001,
    SEQ_STORE  = 3'b010,
    SEQ_NEXT   = 3'b011,
    SEQ_FINISH = 3'b100
  } seq_state_t;

  // Step pace, one step every 1, 2, 4 or 8 clocks
  typedef enum logic [1:0] {
    DIV1 = 2'b00,
    DIV2 = 2'b01,
    DIV4 = 2'b10,
    DIV8 = 2'b11
  } step_div_t;

endpackage

/* hw/rx_cal_sequencer.sv */
// Lane calibration sequencer
// Runs the shared engine on each lane in turn and keeps the trim codes and fail flags

`timescale 1ns/10ps

module rx_cal_sequencer #(
  parameter int NUM_LANES = 4,
  parameter int CODE_W    = 5
) (
  input  logic                        sys_clk,
  input  logic                        rst_n,
  input  logic                        start_cal,
  input  logic                        step_en,
  input  logic [NUM_LANES-1:0]        comp_out,
  output logic [NUM_LANES*CODE_W-1:0] lane_trim,
  output logic                        cal_busy,
  output logic                        cal_done,
  output logic [NUM_LANES-1:0]        cal_fail
);

  import rx_cal_pkg::*;

  localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [IDX_W-1:0] LAST_LANE = IDX_W'(NUM_LANES - 1);

  seq_state_t state;

  logic [IDX_W-1:0]            lane_idx;
  logic [NUM_LANES*CODE_W-1:0] trim_q;
  logic                        eng_start;
  logic                        eng_data;
  logic                        eng_done;
  logic                        eng_no_trip;
  logic [CODE_W-1:0]           eng_code;
  logic                        lane_live;

  assign lane_live = (state == SEQ_RUN) || (state == SEQ_STORE);
  assign eng_start = lane_live;
  assign eng_data  = comp_out[lane_idx];
  assign cal_busy  = lane_live || (state == SEQ_NEXT);
  assign cal_done  = (state == SEQ_FINISH);

  // Active lane sees the sweep code, others hold their stored trim
  always_comb begin
    lane_trim = trim_q;
    if (lane_live) begin
      lane_trim[lane_idx*CODE_W +: CODE_W] = eng_code;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= SEQ_IDLE;
      lane_idx <= '0;
      trim_q   <= '0;
      cal_fail <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start_cal) begin
            lane_idx <= '0;
            state    <= SEQ_RUN;
          end
        end
        SEQ_RUN: if (eng_done) state <= SEQ_STORE;
        SEQ_STORE: begin
          trim_q[lane_idx*CODE_W +: CODE_W] <= eng_code;
          cal_fail[lane_idx]                <= eng_no_trip;
          state                             <= SEQ_NEXT;
        end
        // Engine leaves its done state on this same step
        SEQ_NEXT: begin
          if (step_en) begin
            if (lane_idx == LAST_LANE) begin
              state <= SEQ_FINISH;
            end else begin
              lane_idx <= lane_idx + 1'b1;
              state    <= SEQ_RUN;
            end
          end
        end
        SEQ_FINISH: if (!start_cal) state <= SEQ_IDLE;
        default:    state <= SEQ_IDLE;
      endcase
    end
  end

  rx_offset_cal #(
    .CODE_W(CODE_W)
  ) u_offset_cal (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .step_en       (step_en),
    .start_cal     (eng_start),
    .cal_data      (eng_data),
    .cal_done      (eng_done),
    .no_trip       (eng_no_trip),
    .offs_cal_code (eng_code)
  );

endmodule

/* hw/rx_cal_top.sv */
// Receiver offset calibration top level
// Step timer paces the lane sequencer and its shared sweep engine

`timescale 1ns/10ps

module rx_cal_top #(
  parameter int NUM_LANES = 4,
  parameter int CODE_W    = 5
) (
  input  logic                        sys_clk,
  input  logic                        rst_n,
  input  logic                        start_cal,
  input  rx_cal_pkg::step_div_t       step_div,
  input  logic [NUM_LANES-1:0]        comp_out,
  output logic [NUM_LANES*CODE_W-1:0] lane_trim,
  output logic                        cal_busy,
  output logic                        cal_done,
  output logic [NUM_LANES-1:0]        cal_fail
);

  logic step_en;

  cal_step_timer u_step_timer (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .step_div (step_div),
    .step_en  (step_en)
  );

  rx_cal_sequencer #(
    .NUM_LANES (NUM_LANES),
    .CODE_W    (CODE_W)
  ) u_sequencer (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .start_cal (start_cal),
    .step_en   (step_en),
    .comp_out  (comp_out),
    .lane_trim (lane_trim),
    .cal_busy  (cal_busy),
    .cal_done  (cal_done),
    .cal_fail  (cal_fail)
  );

endmodule

/* hw/rx_offset_cal.sv */
// Comparator offset calibration engine
// Sweeps the trim code up then down, finds both trip points and
// averages them so comparator hysteresis cancels

`timescale 1ns/10ps

module rx_offset_cal #(
  parameter int CODE_W = 5
) (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              step_en,
  input  logic              start_cal,
  input  logic              cal_data,
  output logic              cal_done,
  output logic              no_trip,
  output logic [CODE_W-1:0] offs_cal_code
);

  import rx_cal_pkg::*;

  localparam logic [CODE_W-1:0] CODE_MAX = '1;

  cal_state_t cur_state;
  cal_state_t nxt_state;

  logic [CODE_W-1:0] up_trip;
  logic [CODE_W-1:0] down_trip;
  logic              up_found;
  logic              down_found;
  logic              prev_data;
  logic [1:0]        samp_pair;
  logic [CODE_W:0]   trip_sum;

  // Previous and current comparator sample for edge detection
  assign samp_pair = {prev_data, cal_data};
  assign trip_sum  = {1'b0, up_trip} + {1'b0, down_trip};

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_state <= CAL_IDLE;
    end else begin
      cur_state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state = cur_state;
    if (step_en) begin
      case (cur_state)
        CAL_IDLE: if (start_cal) nxt_state = CAL_UP;
        CAL_UP:   if (offs_cal_code == CODE_MAX) nxt_state = CAL_ROLL;
        CAL_ROLL: nxt_state = CAL_DOWN;
        CAL_DOWN: if (offs_cal_code == '0) nxt_state = CAL_DONE;
        // Result is shown for at least one step before release
        CAL_DONE: if (!start_cal && cal_done) nxt_state = CAL_IDLE;
        default:  nxt_state = CAL_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      offs_cal_code <= '0;
      up_trip       <= '0;
      down_trip     <= '0;
      up_found      <= 1'b0;
      down_found    <= 1'b0;
      prev_data     <= 1'b0;
      no_trip       <= 1'b0;
      cal_done      <= 1'b0;
    end else if (step_en) begin
      case (cur_state)
        CAL_IDLE: begin
          offs_cal_code <= '0;
          up_trip       <= CODE_MAX;
          down_trip     <= '0;
          up_found      <= 1'b0;
          down_found    <= 1'b0;
          prev_data     <= 1'b0;
          no_trip       <= 1'b0;
          cal_done      <= 1'b0;
        end
        CAL_UP: begin
          prev_data <= cal_data;
          // First low to high flip is the up trip point
          if (samp_pair == 2'b01 && !up_found) begin
            up_trip  <= offs_cal_code;
            up_found <= 1'b1;
          end
          if (offs_cal_code != CODE_MAX) begin
            offs_cal_code <= offs_cal_code + 1'b1;
          end
        end
        CAL_ROLL: begin
          offs_cal_code <= CODE_MAX;
          prev_data     <= 1'b0;
          no_trip       <= !up_found;
        end
        CAL_DOWN: begin
          prev_data <= cal_data;
          // Code above the first low sample was the last one reading high
          if (samp_pair == 2'b10 && !down_found) begin
            down_trip  <= offs_cal_code + 1'b1;
            down_found <= 1'b1;
          end
          if (offs_cal_code != '0) begin
            offs_cal_code <= offs_cal_code - 1'b1;
          end
        end
        CAL_DONE: begin
          if (!start_cal && cal_done) begin
            cal_done <= 1'b0;
          end else begin
            offs_cal_code <= trip_sum[CODE_W:1];
            cal_done      <= 1'b1;
          end
        end
        default: begin
          offs_cal_code <= '0;
          prev_data     <= 1'b0;
          cal_done      <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the calibration testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_rx_cal -o sim_rx_cal
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rx_cal > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation reported no failure"
exit 0

/* vlog.f */
hw/rx_cal_pkg.sv
hw/cal_step_timer.sv
hw/rx_offset_cal.sv
hw/rx_cal_sequencer.sv
hw/rx_cal_top.sv
dv/rx_cal_clk_gen.sv
dv/rx_cal_monitor.sv
dv/rx_cal_chk.sv
dv/tb_rx_cal.sv
